//--- design/cancid_pkg.sv
`default_nettype none

package cancid_pkg;

  // Stream contexts
  localparam int NUM_STREAMS = 64;
  localparam int SID_W       = 6;

  // DFA sizing
  localparam int STATE_W     = 4;
  localparam int PATTERN_LEN = 9;
  localparam int COUNT_W     = 16;

  // Literal to detect, first character in the top byte
  localparam logic [8*PATTERN_LEN-1:0] PATTERN = "USER ROOT";
  localparam logic [7:0] PATTERN_FIRST = PATTERN[8*PATTERN_LEN-1 -: 8];

  // AXI4-Lite sizing
  localparam int AXI_ADDR_W = 5;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Register map, byte offsets
  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL  = 5'h00;
  localparam logic [AXI_ADDR_W-1:0] ADDR_EN_LO = 5'h04;
  localparam logic [AXI_ADDR_W-1:0] ADDR_EN_HI = 5'h08;
  localparam logic [AXI_ADDR_W-1:0] ADDR_COUNT = 5'h0C;
  localparam logic [AXI_ADDR_W-1:0] ADDR_FIRED = 5'h10;

  // CTRL register bit positions
  localparam int CTRL_CLEAR_BIT = 0;

  // Automaton state, 0 is idle and ACCEPT_STATE means full match
  typedef logic [STATE_W-1:0] dfa_state_t;

  localparam dfa_state_t ACCEPT_STATE = dfa_state_t'(PATTERN_LEN);

  // One beat of the byte stream
  typedef struct packed {
    logic             valid;
    logic             sop;
    logic             eop;
    logic [SID_W-1:0] sid;
    logic [7:0]       data;
  } byte_beat_t;

  // CSR block towards the detector core
  typedef struct packed {
    logic [NUM_STREAMS-1:0] enable_mask;
    logic                   clear;
  } csr_to_core_t;

  // Detector core status towards the CSR block
  typedef struct packed {
    logic [COUNT_W-1:0] count;
    logic               fired;
  } core_to_csr_t;

endpackage

`default_nettype wire

//--- design/pop3_dfa.sv
`timescale 1ns/1ps
`default_nettype none

module pop3_dfa (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [7:0]             char_in,
  input  logic                   char_vld,
  input  cancid_pkg::dfa_state_t state_in,
  input  logic                   state_vld,
  output cancid_pkg::dfa_state_t state_out,
  output logic                   accept
);

  // Current automaton position
  cancid_pkg::dfa_state_t state_q;

  // Position the next byte is compared against
  cancid_pkg::dfa_state_t base_state;
  cancid_pkg::dfa_state_t next_state;

  // Case folded input byte
  logic [7:0] char_up;

  // Pattern byte expected at base_state
  logic [7:0] expect_char;

  // Fold a-z onto A-Z, everything else passes unchanged
  always_comb
  begin
    if (char_in >= 8'h61 && char_in <= 8'h7a)
      char_up = char_in - 8'h20;
    else
      char_up = char_in;
  end

  // ACCEPT scans on exactly like the idle state
  assign base_state = (state_q >= cancid_pkg::ACCEPT_STATE) ? '0 : state_q;

  // Select the pattern byte for this position
  assign expect_char =
    cancid_pkg::PATTERN[8*(cancid_pkg::PATTERN_LEN-1-int'(base_state)) +: 8];

  // Transition function
  always_comb
  begin
    if (char_up == expect_char)
      // Advance one position along the literal
      next_state = base_state + 1'b1;
    else if (char_up == cancid_pkg::PATTERN_FIRST)
      // A stray 'U' may start a fresh attempt
      next_state = cancid_pkg::dfa_state_t'(1);
    else
      next_state = '0;
  end

  // State register
  // A restored state wins over a byte in the same cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= '0;
    end
    else if (state_vld)
    begin
      state_q <= state_in;
    end
    else if (char_vld)
    begin
      state_q <= next_state;
    end
  end

  assign state_out = state_q;

  // High for the whole cycle the automaton sits in ACCEPT
  assign accept = (state_q == cancid_pkg::ACCEPT_STATE);

endmodule

`default_nettype wire

//--- design/stream_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module stream_tracker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cancid_pkg::byte_beat_t       beat_in,
  input  logic                         clear,
  output logic                         load_state,
  output logic                         new_stream,
  output logic [cancid_pkg::SID_W-1:0] sid
);

  // One bit per stream, set once a packet of that stream has started
  logic [cancid_pkg::NUM_STREAMS-1:0] seen;

  // Packet start seen on the input
  logic sop_hit;

  assign sop_hit = beat_in.valid && beat_in.sop;

  // Seen bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= '0;
    end
    else if (clear)
    begin
      // Host wipes all stream history
      seen <= '0;
    end
    else if (sop_hit)
    begin
      seen[beat_in.sid] <= 1'b1;
    end
  end

  // Restore request towards the matcher, one cycle after sop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_state <= 1'b0;
      new_stream <= 1'b0;
    end
    else
    begin
      load_state <= sop_hit;
      // A clear in the sop cycle makes every stream new
      new_stream <= sop_hit && (clear || !seen[beat_in.sid]);
    end
  end

  // Stream id that goes with load_state
  always_ff @(posedge clk)
  begin
    if (sop_hit)
      sid <= beat_in.sid;
  end

endmodule

`default_nettype wire

//--- design/cancid_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module cancid_matcher (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cancid_pkg::byte_beat_t       beat_in,
  input  logic                         load_state,
  input  logic                         new_stream,
  input  logic [cancid_pkg::SID_W-1:0] load_sid,
  input  cancid_pkg::csr_to_core_t     csr_in,
  output cancid_pkg::core_to_csr_t     status
);

  // Saved automaton position per stream
  cancid_pkg::dfa_state_t state_mem [cancid_pkg::NUM_STREAMS];

  // Restore stage
  cancid_pkg::dfa_state_t state_in;
  logic                   state_in_vld;

  // Input register stage
  logic [7:0]                   char_r;
  logic                         valid_r;
  cancid_pkg::dfa_state_t       state_in_r;
  logic                         state_in_vld_r;
  logic                         eop_r;
  logic [cancid_pkg::SID_W-1:0] sid_r;

  // Alongside the DFA state register
  logic                         eop_dfa;
  logic [cancid_pkg::SID_W-1:0] sid_dfa;

  // DFA outputs and their register stage
  cancid_pkg::dfa_state_t       state_out;
  logic                         accept;
  cancid_pkg::dfa_state_t       state_out_r;
  logic                         accept_r;
  logic                         eop_out_r;
  logic [cancid_pkg::SID_W-1:0] sid_out_r;

  // Packet level match bookkeeping
  logic                           speculative_match;
  logic                           pkt_match;
  logic                           stream_en;
  logic [cancid_pkg::COUNT_W-1:0] count;
  logic                           fired;

  // Match in this packet so far, including the last byte's accept
  assign pkt_match = speculative_match || accept_r;
  assign stream_en = csr_in.enable_mask[sid_out_r];

  // Fetch saved state, or start a new stream from idle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= load_state;
    if (load_state)
      state_in <= new_stream ? '0 : state_mem[load_sid];
  end

  // Single write port: end of packet save, else zero a new stream's slot
  always_ff @(posedge clk)
  begin
    if (eop_out_r && stream_en)
      state_mem[sid_out_r] <= state_out_r;
    else if (load_state && new_stream)
      state_mem[load_sid] <= '0;
  end

  // All DFA inputs and outputs registered for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_r        <= 1'b0;
      state_in_vld_r <= 1'b0;
      eop_r          <= 1'b0;
      eop_dfa        <= 1'b0;
      eop_out_r      <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      // sop beat carries no character
      valid_r        <= beat_in.valid && !beat_in.sop;
      state_in_vld_r <= state_in_vld;
      eop_r          <= beat_in.valid && !beat_in.sop && beat_in.eop;
      eop_dfa        <= eop_r;
      eop_out_r      <= eop_dfa;
      accept_r       <= accept;
    end
    char_r      <= beat_in.data;
    sid_r       <= beat_in.sid;
    state_in_r  <= state_in;
    sid_dfa     <= sid_r;
    sid_out_r   <= sid_dfa;
    state_out_r <= state_out;
  end

  pop3_dfa u_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_in   (char_r),
    .char_vld  (valid_r),
    .state_in  (state_in_r),
    .state_vld (state_in_vld_r),
    .state_out (state_out),
    .accept    (accept)
  );

  // Flag and count, finalised at the delayed eop
  always_ff @(posedge clk)
  begin
    if (!rst_n || csr_in.clear)
    begin
      speculative_match <= 1'b0;
      count             <= '0;
      fired             <= 1'b0;
    end
    else if (eop_out_r)
    begin
      // Disabled streams simply drop the flag
      speculative_match <= 1'b0;
      if (stream_en && pkt_match)
      begin
        count <= count + 1'b1;
        fired <= 1'b1;
      end
    end
    else if (load_state)
      speculative_match <= 1'b0;
    else if (accept_r)
      speculative_match <= 1'b1;
  end

  assign status.count = count;
  assign status.fired = fired;

endmodule

`default_nettype wire

//--- design/cancid_csr.sv
`timescale 1ns/1ps
`default_nettype none

module cancid_csr (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [cancid_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [cancid_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [cancid_pkg::AXI_STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [cancid_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [cancid_pkg::AXI_DATA_W-1:0] rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  input  cancid_pkg::core_to_csr_t          status,
  output cancid_pkg::csr_to_core_t          ctrl
);

  logic wr_go;
  logic wr_fire;
  logic rd_go;
  logic rd_fire;
  logic [cancid_pkg::AXI_DATA_W-1:0] rd_mux;

  // Accept AW and W together once both are present and no response pending
  assign wr_go   = awvalid && wvalid && !awready && !bvalid;
  assign wr_fire = awready && awvalid && wready && wvalid;
  assign rd_go   = arvalid && !arready && !rvalid;
  assign rd_fire = arready && arvalid;

  // Never an error response
  assign bresp = cancid_pkg::RESP_OKAY;
  assign rresp = cancid_pkg::RESP_OKAY;

  // Write channel handshake
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end
    else
    begin
      awready <= wr_go;
      wready  <= wr_go;
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  // Register writes, byte lanes honour wstrb
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ctrl <= '0;
    end
    else
    begin
      // Clear is a one cycle pulse
      ctrl.clear <= wr_fire && (awaddr == cancid_pkg::ADDR_CTRL) && wstrb[0] &&
                    wdata[cancid_pkg::CTRL_CLEAR_BIT];
      for (int b = 0; b < cancid_pkg::AXI_STRB_W; b++)
      begin
        if (wr_fire && wstrb[b] && awaddr == cancid_pkg::ADDR_EN_LO)
          ctrl.enable_mask[8*b +: 8] <= wdata[8*b +: 8];
        if (wr_fire && wstrb[b] && awaddr == cancid_pkg::ADDR_EN_HI)
          ctrl.enable_mask[cancid_pkg::AXI_DATA_W + 8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // Read decode, unmapped offsets return zero
  always_comb
  begin
    rd_mux = '0;
    case (araddr)
      cancid_pkg::ADDR_EN_LO: rd_mux = ctrl.enable_mask[cancid_pkg::AXI_DATA_W-1:0];
      cancid_pkg::ADDR_EN_HI: rd_mux = ctrl.enable_mask[cancid_pkg::NUM_STREAMS-1 -: 32];
      cancid_pkg::ADDR_COUNT: rd_mux[cancid_pkg::COUNT_W-1:0] = status.count;
      cancid_pkg::ADDR_FIRED: rd_mux[0] = status.fired;
      default: rd_mux = '0;
    endcase
  end

  // Read channel, data sampled at the AR handshake
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= rd_go;
      if (rd_fire)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
    if (rd_fire)
      rdata <= rd_mux;
  end

endmodule

`default_nettype wire

//--- design/cancid_top.sv
`timescale 1ns/1ps
`default_nettype none

module cancid_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  cancid_pkg::byte_beat_t            beat_in,
  input  logic [cancid_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [cancid_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [cancid_pkg::AXI_STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [cancid_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [cancid_pkg::AXI_DATA_W-1:0] rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready
);

  // Tracker to matcher restore request
  logic                         load_state;
  logic                         new_stream;
  logic [cancid_pkg::SID_W-1:0] load_sid;

  // Host control and detector status
  cancid_pkg::csr_to_core_t csr_ctrl;
  cancid_pkg::core_to_csr_t core_status;

  stream_tracker u_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_in    (beat_in),
    .clear      (csr_ctrl.clear),
    .load_state (load_state),
    .new_stream (new_stream),
    .sid        (load_sid)
  );

  cancid_matcher u_matcher (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_in    (beat_in),
    .load_state (load_state),
    .new_stream (new_stream),
    .load_sid   (load_sid),
    .csr_in     (csr_ctrl),
    .status     (core_status)
  );

  cancid_csr u_csr (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .status  (core_status),
    .ctrl    (csr_ctrl)
  );

endmodule

`default_nettype wire

//--- verif/cancid_props.sv
`timescale 1ns/1ps
`default_nettype none

module cancid_props (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load_state,
  input  logic [cancid_pkg::COUNT_W-1:0] count,
  input  logic                           clear,
  input  logic                           eop_out,
  input  cancid_pkg::dfa_state_t         dfa_state,
  input  logic                           awvalid,
  input  logic                           wvalid,
  input  logic                           arvalid,
  input  logic                           bvalid,
  input  logic                           rvalid
);

  // Restore request from the tracker is a single cycle pulse
  load_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    load_state |=> !load_state)
    else $error("load_state high for two consecutive cycles");

  // Count moves only at the delayed eop or on a host clear
  count_update_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(count) |-> ($past(eop_out) || $past(clear)))
    else $error("count changed outside the delayed eop and clear");

  // Automaton never leaves the pattern positions
  dfa_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    dfa_state <= cancid_pkg::ACCEPT_STATE)
    else $error("DFA state above ACCEPT");

  // A write response needs both AW and W on the bus first
  bvalid_cause_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> $past(awvalid && wvalid))
    else $error("bvalid raised without a write request");

  // Read data only follows an AR request
  rvalid_cause_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rvalid) |-> $past(arvalid))
    else $error("rvalid raised without a read request");

endmodule

// Top level is where the tracker, matcher and CSR signals meet
bind cancid_top cancid_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .load_state (load_state),
  .count      (core_status.count),
  .clear      (csr_ctrl.clear),
  .eop_out    (u_matcher.eop_out_r),
  .dfa_state  (u_matcher.state_out),
  .awvalid    (awvalid),
  .wvalid     (wvalid),
  .arvalid    (arvalid),
  .bvalid     (bvalid),
  .rvalid     (rvalid)
);

`default_nettype wire

//--- verif/cancid_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cancid_tb;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 10;
  localparam logic [31:0] SEED         = 32'hbd92_e2bf;
  localparam string       PATTERN_TEXT = "USER ROOT";
  localparam int          ACCEPT_POS   = 9;

  // Run length bound: packets, AXI transfers and a margin
  localparam int NUM_PACKETS    = 13;
  localparam int MAX_PKT_CYCLES = 50;
  localparam int NUM_AXI        = 21;
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * MAX_PKT_CYCLES + 20 * NUM_AXI + 500;

  logic                              clk;
  logic                              rst_n;
  cancid_pkg::byte_beat_t            beat_in;
  logic [cancid_pkg::AXI_ADDR_W-1:0] awaddr;
  logic                              awvalid;
  logic                              awready;
  logic [cancid_pkg::AXI_DATA_W-1:0] wdata;
  logic [cancid_pkg::AXI_STRB_W-1:0] wstrb;
  logic                              wvalid;
  logic                              wready;
  logic [1:0]                        bresp;
  logic                              bvalid;
  logic                              bready;
  logic [cancid_pkg::AXI_ADDR_W-1:0] araddr;
  logic                              arvalid;
  logic                              arready;
  logic [cancid_pkg::AXI_DATA_W-1:0] rdata;
  logic [1:0]                        rresp;
  logic                              rvalid;
  logic                              rready;

  // Result bookkeeping, index 0 collects checks outside the six behaviors
  int errors      = 0;
  int checks_run  = 0;
  int cycle_count = 0;
  bit checked [0:6];

  // Bytes of the packet being built
  logic [7:0] pkt_bytes [$];

  // Reference model of the detector
  int          model_saved [cancid_pkg::NUM_STREAMS];
  bit          model_seen [cancid_pkg::NUM_STREAMS];
  logic [63:0] model_mask;
  int          model_count;
  bit          model_fired;

  cancid_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat_in (beat_in),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard stop if a handshake never completes
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [7:0] fold_upper(input logic [7:0] c);
    if (c >= "a" && c <= "z")
      return c - 8'h20;
    return c;
  endfunction

  // Letters flip to lower case half of the time
  function automatic logic [7:0] random_case(input logic [7:0] c);
    if (c >= "A" && c <= "Z" && $urandom_range(1) == 1)
      return c + 8'h20;
    return c;
  endfunction

  function automatic bit in_pattern(input logic [7:0] c);
    for (int i = 0; i < PATTERN_TEXT.len(); i++)
      if (c == PATTERN_TEXT[i])
        return 1'b1;
    return 1'b0;
  endfunction

  // Letters outside the pattern, so filler never builds "ROOT"
  function automatic logic [7:0] filler_char();
    logic [7:0] c;
    do
      c = 8'h41 + 8'($urandom_range(25));
    while (in_pattern(c));
    return random_case(c);
  endfunction

  // Pattern position after one byte, with the fall back to 'U' or idle
  function automatic int next_position(input int pos, input logic [7:0] c);
    logic [7:0] up;
    int         base;
    up   = fold_upper(c);
    base = (pos == ACCEPT_POS) ? 0 : pos;
    if (up == PATTERN_TEXT[base])
      return base + 1;
    if (up == PATTERN_TEXT[0])
      return 1;
    return 0;
  endfunction

  task automatic add_text(input string s, input bit mixed);
    for (int i = 0; i < s.len(); i++)
      pkt_bytes.push_back(mixed ? random_case(s[i]) : s[i]);
  endtask

  task automatic add_filler();
    int n;
    n = $urandom_range(6, 2);
    repeat (n) pkt_bytes.push_back(filler_char());
  endtask

  // Expected effect of one packet on the saved state and the count
  task automatic model_packet(input int sid);
    int pos;
    bit hit;
    if (!model_seen[sid])
      model_saved[sid] = 0;
    model_seen[sid] = 1'b1;
    pos = model_saved[sid];
    hit = 1'b0;
    foreach (pkt_bytes[i])
    begin
      pos = next_position(pos, pkt_bytes[i]);
      if (pos == ACCEPT_POS)
        hit = 1'b1;
    end
    if (model_mask[sid])
    begin
      model_saved[sid] = pos;
      if (hit)
      begin
        model_count++;
        model_fired = 1'b1;
      end
    end
  endtask

  // Sop beat, two idle cycles, data beats, then a gap
  task automatic send_packet(input int sid);
    model_packet(sid);
    @(negedge clk);
    beat_in       = '0;
    beat_in.valid = 1'b1;
    beat_in.sop   = 1'b1;
    beat_in.sid   = cancid_pkg::SID_W'(sid);
    @(negedge clk);
    beat_in = '0;
    @(negedge clk);
    foreach (pkt_bytes[i])
    begin
      @(negedge clk);
      beat_in.valid = 1'b1;
      beat_in.sop   = 1'b0;
      beat_in.eop   = (i == pkt_bytes.size() - 1);
      beat_in.sid   = cancid_pkg::SID_W'(sid);
      beat_in.data  = pkt_bytes[i];
    end
    @(negedge clk);
    beat_in = '0;
    // Count settles well inside this gap
    repeat (5) @(negedge clk);
    pkt_bytes.delete();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input int behavior);
    checked[behavior] = 1'b1;
    checks_run++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do
      @(negedge clk);
    while (!awready);
    // W is accepted in the same cycle as AW
    check_value("wready", 32'h1, 32'(wready), 0);
    // Handshake taken at the edge just passed
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
      @(negedge clk);
    check_value("bresp", 32'(cancid_pkg::RESP_OKAY), 32'(bresp), 0);
  endtask

  task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do
      @(negedge clk);
    while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    resp = rresp;
  endtask

  task automatic read_check(input string name, input logic [4:0] addr,
                            input logic [31:0] expected, input int behavior);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value({name, " rresp"}, 32'(cancid_pkg::RESP_OKAY), 32'(resp), behavior);
    check_value(name, expected, data, behavior);
  endtask

  task automatic set_mask(input logic [63:0] mask);
    model_mask = mask;
    axi_write(cancid_pkg::ADDR_EN_LO, mask[31:0]);
    axi_write(cancid_pkg::ADDR_EN_HI, mask[63:32]);
  endtask

  // Host clear forgets every stream and zeroes the count
  task automatic clear_detector();
    axi_write(cancid_pkg::ADDR_CTRL, 32'h1);
    foreach (model_seen[i])
      model_seen[i] = 1'b0;
    model_count = 0;
    model_fired = 1'b0;
  endtask

  initial
  begin
    int          sid_a;
    int          sid_b;
    int          sid_c;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    beat_in  = '0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b1;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b1;
    foreach (model_seen[i])
    begin
      model_seen[i]  = 1'b0;
      model_saved[i] = 0;
    end
    model_mask  = '0;
    model_count = 0;
    model_fired = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // Three distinct streams, one per mask half, the third starts disabled
    sid_a = $urandom_range(31);
    sid_b = $urandom_range(63, 32);
    do
      sid_c = $urandom_range(63);
    while (sid_c == sid_a || sid_c == sid_b);

    // Enable mask readback and unmapped offsets
    set_mask((64'd1 << sid_a) | (64'd1 << sid_b));
    read_check("EN_LO", cancid_pkg::ADDR_EN_LO, model_mask[31:0], 6);
    read_check("EN_HI", cancid_pkg::ADDR_EN_HI, model_mask[63:32], 6);
    read_check("unmapped 0x14", 5'h14, 32'h0, 6);
    read_check("unmapped 0x1C", 5'h1C, 32'h0, 6);

    // Mixed case match and the fired flag around it
    read_check("FIRED", cancid_pkg::ADDR_FIRED, 32'(model_fired), 5);
    add_filler();
    add_text("uSeR rOoT", 1'b0);
    add_filler();
    send_packet(sid_a);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 5);
    read_check("FIRED", cancid_pkg::ADDR_FIRED, 32'(model_fired), 5);

    // Two matches in one packet add only one
    add_filler();
    add_text("USER ROOT", 1'b1);
    add_filler();
    add_text("USER ROOT", 1'b1);
    add_filler();
    send_packet(sid_a);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 1);

    // Split match with other streams in between
    add_filler();
    add_text("USER R", 1'b1);
    send_packet(sid_b);
    add_filler();
    send_packet(sid_a);
    add_filler();
    send_packet(sid_c);
    add_text("OOT", 1'b1);
    add_filler();
    send_packet(sid_b);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 2);

    // Disabled stream keeps neither count nor prefix state
    add_filler();
    add_text("USER ROOT", 1'b1);
    add_filler();
    send_packet(sid_c);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 3);
    add_filler();
    add_text("USER R", 1'b1);
    send_packet(sid_c);
    set_mask(model_mask | (64'd1 << sid_c));
    add_text("OOT", 1'b1);
    add_filler();
    send_packet(sid_c);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 3);

    // Clear drops the saved prefix of a known stream
    add_filler();
    add_text("USER R", 1'b1);
    send_packet(sid_a);
    clear_detector();
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 4);
    read_check("FIRED", cancid_pkg::ADDR_FIRED, 32'(model_fired), 4);
    add_text("OOT", 1'b1);
    add_filler();
    send_packet(sid_a);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 4);

    // Detection still works after the clear
    add_filler();
    add_text("USER ROOT", 1'b1);
    add_filler();
    send_packet(sid_b);
    read_check("COUNT", cancid_pkg::ADDR_COUNT, 32'(model_count), 4);
    read_check("FIRED", cancid_pkg::ADDR_FIRED, 32'(model_fired), 4);

    for (int b = 1; b <= 6; b++)
    begin
      if (!checked[b])
      begin
        errors++;
        $display("Behavior %0d was never checked", b);
      end
    end
    $display("Checks run: %0d, errors: %0d", checks_run, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/cancid_pkg.sv
design/pop3_dfa.sv
design/stream_tracker.sv
design/cancid_matcher.sv
design/cancid_csr.sv
design/cancid_top.sv
verif/cancid_props.sv
verif/cancid_tb.sv

//--- Bender.yml
package:
  name: cancid

sources:
  - design/cancid_pkg.sv
  - design/pop3_dfa.sv
  - design/stream_tracker.sv
  - design/cancid_matcher.sv
  - design/cancid_csr.sv
  - design/cancid_top.sv
  - target: simulation
    files:
      - verif/cancid_props.sv
      - verif/cancid_tb.sv
